// ==== l2_cache.f ====
+incdir+hdl
hdl/bus_pkg.sv
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/lru_order.sv
hdl/miss_ctrl.sv
hdl/l2_cache.sv
bench/l2_cache_checker.sv
bench/l2_cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the l2 cache testbench

SRCS := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

obj_dir/Vl2_cache_tb: l2_cache.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module l2_cache_tb -f l2_cache.f

run: obj_dir/Vl2_cache_tb
	./obj_dir/Vl2_cache_tb +verilator+error+limit+1000 > sim.log 2>&1; \
		status=$$?; cat sim.log; exit $$status
	! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== bench/l2_cache_tb.sv ====
////////////////////////////////////////
// l2 cache testbench
// clock, reset, stalling memory model
// directed tests, random traffic, summary
////////////////////////////////////////

`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_cache_tb
    import bus_pkg::*;
();

    typedef logic [`N_TAG_BITS-1:0] tag_t;

    logic   CLK;
    logic   nRST;
    logic   proc_ren;
    logic   proc_wen;
    addr_t  proc_addr;
    word_t  proc_wdata;
    word_t  proc_rdata;
    logic   proc_busy;
    logic   mem_ren;
    logic   mem_wen;
    addr_t  mem_addr;
    word_t  mem_wdata;
    word_t  mem_rdata;
    logic   mem_busy;

    integer seed = 32'h5b33;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    word_t  mem_model [addr_t]; // what the cache wrote back
    word_t  exp_mem [addr_t];   // processor view of memory
    addr_t  rd_addrs [$];       // completed fetch words
    addr_t  wr_addrs [$];       // completed write-back words
    word_t  wr_datas [$];
    tag_t   lru_q [$];          // predicted recency, least recent first
    event   abort_ev;
    string  abort_msg;

    l2_cache uut (.*);

    bind l2_cache l2_cache_checker chk (
        .CLK(CLK), .nRST(nRST), .proc_ren(proc_ren), .proc_wen(proc_wen),
        .proc_busy(proc_busy), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_busy(mem_busy)
    );

    initial begin : clock_gen
        CLK = 1'b0;
        forever #2 CLK = ~CLK; // 4 ns period
    end

    ////////////////////////////////////////
    // reference helpers
    ////////////////////////////////////////

    // untouched memory, mixes all address bits
    function automatic word_t fill_pattern(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t exp_read(addr_t a);
        return exp_mem.exists(a) ? exp_mem[a] : fill_pattern(a);
    endfunction

    // tag | set | word | byte
    function automatic addr_t make_addr(tag_t tag, int set_i, int blk);
        return {tag, set_i[`N_SET_BITS-1:0], blk[`N_BLOCK_BITS-1:0], 2'b00};
    endfunction

    function automatic int total_errors();
        return errors + uut.chk.fail_count;
    endfunction

    task automatic lru_note(input tag_t tag);
        for (int i = 0; i < lru_q.size(); i++) begin
            if (lru_q[i] == tag) begin
                lru_q.delete(i); // move to most recent end
                break;
            end
        end
        lru_q.push_back(tag);
        if (lru_q.size() > `ASSOC) begin
            void'(lru_q.pop_front()); // evicted
        end
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got);
            errors++;
        end
    endtask

    task automatic test_done(input string name, input int err_start);
        tests_run++;
        if (total_errors() != err_start) begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, total_errors() - err_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    // busy until a random grant, sampled mid-cycle, driven on the edge
    initial begin : mem_model_proc
        logic  req_s;
        logic  wen_s;
        logic  busy_s;
        addr_t addr_s;
        word_t wdata_s;
        word_t rnd;
        mem_busy  = 1'b1;
        mem_rdata = '0;
        forever begin
            @(negedge CLK);
            req_s   = mem_ren | mem_wen;
            wen_s   = mem_wen;
            busy_s  = mem_busy;
            addr_s  = mem_addr;
            wdata_s = mem_wdata;
            rnd     = $random(seed);
            @(posedge CLK);
            if (req_s && busy_s) begin
                if (rnd[0]) begin
                    mem_busy <= 1'b1; // random stall
                end else begin
                    mem_busy  <= 1'b0;
                    mem_rdata <= mem_model.exists(addr_s) ? mem_model[addr_s]
                                                          : fill_pattern(addr_s);
                end
            end else begin
                if (req_s) begin // word completed in the cycle just ended
                    if (wen_s) begin
                        mem_model[addr_s] = wdata_s;
                        wr_addrs.push_back(addr_s);
                        wr_datas.push_back(wdata_s);
                    end else begin
                        rd_addrs.push_back(addr_s);
                    end
                end
                mem_busy <= 1'b1;
            end
        end
    end

    initial begin : abort_watch
        @(abort_ev);
        $display("%s", abort_msg);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // processor requests
    ////////////////////////////////////////

    task automatic cache_access(input logic wr, input addr_t addr, input word_t wdata,
                                output word_t rdata, output int cycles);
        bit done;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        @(posedge CLK);
        proc_ren   <= !wr;
        proc_wen   <= wr;
        proc_addr  <= addr;
        proc_wdata <= wdata;
        while (!done && cycles < 400) begin
            @(negedge CLK);
            cycles++;
            if (!proc_busy) begin
                done  = 1'b1;
                rdata = proc_rdata;
            end
        end
        @(posedge CLK);
        proc_ren <= 1'b0;
        proc_wen <= 1'b0;
        if (!done) begin
            $sformat(abort_msg, "timeout: request to 0x%08h never finished", addr);
            -> abort_ev;
            forever @(posedge CLK); // park until the abort ends the run
        end else if (wr) begin
            exp_mem[addr] = wdata;
        end else begin
            check_value("proc_rdata", exp_read(addr), rdata);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin : main
        word_t rdata;
        word_t rnd;
        int    cycles;
        int    err0;
        addr_t base;
        tag_t  victim;
        tag_t  keep [3];
        int    touch_seq [4] = '{2, 0, 3, 1};
        nRST       = 1'b0;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        err0 = total_errors(); // cold read, block fetch order
        base = make_addr(tag_t'(32'h100), 0, 0);
        rd_addrs.delete();
        cache_access(1'b0, base + 4, '0, rdata, cycles);
        check_value("mem_ren count", 4, rd_addrs.size());
        for (int i = 0; i < 4 && i < rd_addrs.size(); i++) begin
            check_value("mem_addr", base + 4 * i, rd_addrs[i]);
        end
        test_done("1 cold read", err0);

        err0 = total_errors(); // same block, hit in one cycle
        rd_addrs.delete();
        wr_addrs.delete();
        cache_access(1'b0, base + 8, '0, rdata, cycles);
        check_value("hit cycles", 1, cycles);
        check_value("mem_ren count", 0, rd_addrs.size());
        check_value("mem_wen count", 0, wr_addrs.size());
        test_done("2 read hit", err0);

        err0 = total_errors();
        cache_access(1'b1, base + 12, 32'hc0de_0003, rdata, cycles);
        check_value("hit cycles", 1, cycles);
        cache_access(1'b0, base + 12, '0, rdata, cycles);
        test_done("3 write hit", err0);

        err0 = total_errors(); // dirty least recent block leaves first
        cache_access(1'b1, make_addr(tag_t'(32'h200), 1, 2), 32'hdead_0204, rdata, cycles);
        for (int t = 1; t < 4; t++) begin
            cache_access(1'b0, make_addr(tag_t'(32'h200 + t), 1, 0), '0, rdata, cycles);
        end
        wr_addrs.delete();
        wr_datas.delete();
        cache_access(1'b0, make_addr(tag_t'(32'h204), 1, 0), '0, rdata, cycles);
        check_value("mem_wen count", 4, wr_addrs.size());
        for (int i = 0; i < 4 && i < wr_addrs.size(); i++) begin
            check_value("mem_addr", make_addr(tag_t'(32'h200), 1, i), wr_addrs[i]);
            check_value("mem_wdata", exp_read(make_addr(tag_t'(32'h200), 1, i)), wr_datas[i]);
        end
        cache_access(1'b0, make_addr(tag_t'(32'h200), 1, 2), '0, rdata, cycles);
        test_done("4 write-back", err0);

        err0 = total_errors(); // replacement follows recency
        lru_q.delete();
        for (int t = 0; t < 4; t++) begin
            cache_access(1'b0, make_addr(tag_t'(32'h300 + t), 6, 0), '0, rdata, cycles);
            lru_note(tag_t'(32'h300 + t));
        end
        foreach (touch_seq[i]) begin
            cache_access(1'b0, make_addr(tag_t'(32'h300 + touch_seq[i]), 6, 1), '0,
                         rdata, cycles);
            lru_note(tag_t'(32'h300 + touch_seq[i]));
        end
        victim = lru_q[0];
        cache_access(1'b0, make_addr(tag_t'(32'h304), 6, 0), '0, rdata, cycles);
        lru_note(tag_t'(32'h304));
        for (int i = 0; i < 3; i++) begin
            keep[i] = lru_q[i]; // survivors besides the new block
        end
        foreach (keep[i]) begin
            rd_addrs.delete();
            cache_access(1'b0, make_addr(keep[i], 6, 3), '0, rdata, cycles);
            lru_note(keep[i]);
            check_value("mem_ren count", 0, rd_addrs.size());
        end
        rd_addrs.delete();
        cache_access(1'b0, make_addr(victim, 6, 0), '0, rdata, cycles);
        check_value("mem_ren count", 4, rd_addrs.size()); // evicted block comes back
        test_done("5 lru victim", err0);

        err0 = total_errors(); // six tags over two sets, stalls throughout
        for (int n = 0; n < 80; n++) begin
            rnd  = $random(seed);
            base = make_addr(tag_t'(32'h400 + rnd[15:8] % 6), rnd[1] ? 5 : 2, int'(rnd[3:2]));
            if (rnd[0]) begin
                rnd = $random(seed);
                cache_access(1'b1, base, rnd, rdata, cycles);
            end else begin
                cache_access(1'b0, base, '0, rdata, cycles);
            end
        end
        test_done("6 random traffic", err0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/l2_cache_checker.sv ====
////////////////////////////////////////
// bus protocol assertions
// bound to the l2 cache top
////////////////////////////////////////

`timescale 1ns/1ps

module l2_cache_checker
    import bus_pkg::*;
(
    input logic  CLK,
    input logic  nRST,
    input logic  proc_ren,
    input logic  proc_wen,
    input logic  proc_busy,
    input logic  mem_ren,
    input logic  mem_wen,
    input addr_t mem_addr,
    input word_t mem_wdata,
    input logic  mem_busy
);

    int   fail_count = 0; // assertion failures so far
    logic proc_req;
    logic mem_req;

    assign proc_req = proc_ren | proc_wen;
    assign mem_req  = mem_ren | mem_wen;

    // one direction at a time on the memory bus
    rw_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
    else begin
        $error("mem_ren and mem_wen high in the same cycle");
        fail_count = fail_count + 1;
    end

    // stalled request keeps direction, address and data
    req_hold: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req && mem_busy |=> mem_ren == $past(mem_ren) && mem_wen == $past(mem_wen)
            && mem_addr == $past(mem_addr) && mem_wdata == $past(mem_wdata))
    else begin
        $error("memory request changed while mem_busy was high");
        fail_count = fail_count + 1;
    end

    // completion only for a request that is there
    done_with_req: assert property (@(posedge CLK) disable iff (!nRST)
        !proc_busy |-> proc_req)
    else begin
        $error("proc_busy low without a processor request");
        fail_count = fail_count + 1;
    end

    // no request or completing cycle means no miss in flight
    mem_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        (!proc_req || !proc_busy) |-> !mem_req)
    else begin
        $error("memory request outside a miss");
        fail_count = fail_count + 1;
    end

    word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req |-> mem_addr[1:0] == 2'b00)
    else begin
        $error("memory address with a non-zero byte offset");
        fail_count = fail_count + 1;
    end

endmodule

// ==== hdl/l2_cache.sv ====
////////////////////////////////////////
// l2 cache top
// store, lru order and miss controller
////////////////////////////////////////

`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_cache
    import bus_pkg::*, cache_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    // processor side
    input  logic  proc_ren,
    input  logic  proc_wen,
    input  addr_t proc_addr,
    input  word_t proc_wdata,
    output word_t proc_rdata,
    output logic  proc_busy,
    // memory side
    output logic  mem_ren,
    output logic  mem_wen,
    output addr_t mem_addr,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_busy
);

    cache_addr_u              req_addr;     // decoded request address
    way_t                     victim_way;   // lru pick for this set
    way_t                     hit_way;
    way_t                     touch_way;
    logic [`N_BLOCK_BITS-1:0] word_num;     // miss word counter
    logic                     hit;
    logic                     wr_word;
    logic                     fill_word;
    logic                     set_tag;
    logic                     clr_dirty;
    logic                     touch;
    word_t                    fill_data;    // write hit or fill word
    word_t                    victim_word;
    frame_tag_t               victim_tag;

    assign req_addr.raw = proc_addr; // one decode, shared by all units

    cache_store u_store (
        .CLK(CLK), .nRST(nRST),
        .req_addr(req_addr), .victim_way(victim_way), .word_num(word_num),
        .wr_word(wr_word), .fill_word(fill_word), .wr_data(fill_data),
        .set_tag(set_tag), .clr_dirty(clr_dirty),
        .hit(hit), .hit_way(hit_way), .hit_word(proc_rdata),
        .victim_tag(victim_tag), .victim_word(victim_word)
    );

    lru_order u_lru (
        .CLK(CLK), .nRST(nRST),
        .set_idx(req_addr.f.set_idx),
        .touch(touch), .touch_way(touch_way),
        .victim_way(victim_way)
    );

    miss_ctrl u_ctrl (
        .CLK(CLK), .nRST(nRST),
        .proc_ren(proc_ren), .proc_wen(proc_wen), .proc_wdata(proc_wdata),
        .req_addr(req_addr), .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_tag(victim_tag), .victim_word(victim_word),
        .proc_busy(proc_busy),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_busy(mem_busy),
        .word_num(word_num), .wr_word(wr_word), .fill_word(fill_word),
        .fill_data(fill_data), .set_tag(set_tag), .clr_dirty(clr_dirty),
        .touch(touch), .touch_way(touch_way)
    );

endmodule

// ==== hdl/miss_ctrl.sv ====
////////////////////////////////////////
// miss controller fsm
// word counter, write-back and fetch on the memory bus
////////////////////////////////////////

`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module miss_ctrl
    import bus_pkg::*, cache_pkg::*;
(
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     proc_ren,
    input  logic                     proc_wen,
    input  word_t                    proc_wdata,
    input  cache_addr_u              req_addr,
    input  logic                     hit,
    input  way_t                     hit_way,
    input  way_t                     victim_way,
    input  frame_tag_t               victim_tag,
    input  word_t                    victim_word,
    output logic                     proc_busy,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output addr_t                    mem_addr,
    output word_t                    mem_wdata,
    input  word_t                    mem_rdata,
    input  logic                     mem_busy,
    output logic [`N_BLOCK_BITS-1:0] word_num,
    output logic                     wr_word,
    output logic                     fill_word,
    output word_t                    fill_data,
    output logic                     set_tag,
    output logic                     clr_dirty,
    output logic                     touch,
    output way_t                     touch_way
);

    localparam logic [`N_BLOCK_BITS-1:0] last_idx = `N_BLOCK_BITS'(`BLOCK_SIZE - 1);

    ctrl_state_t              state, next_state;
    logic [`N_BLOCK_BITS-1:0] next_word_num;
    logic                     req;
    logic                     mem_done;  // word transfer completes this cycle
    logic                     last_word;
    cache_addr_u              bus_addr;

    assign req       = proc_ren | proc_wen;
    assign mem_done  = !mem_busy;
    assign last_word = (word_num == last_idx);

    ////////////////////////////////////////
    // memory bus address and data
    ////////////////////////////////////////

    // block base plus word counter, victim tag on write-back
    always_comb begin : bus_addr_build
        bus_addr.f.tag      = (state == write_back) ? victim_tag.tag : req_addr.f.tag;
        bus_addr.f.set_idx  = req_addr.f.set_idx;
        bus_addr.f.blk_off  = word_num;
        bus_addr.f.byte_off = 2'b00;
    end

    assign mem_addr  = bus_addr.raw;
    assign mem_wdata = victim_word;                                 // store reads victim at word_num
    assign fill_data = (state == fetch) ? mem_rdata : proc_wdata;   // fill or write hit
    assign touch_way = hit_way;                                     // completion is always a hit

    ////////////////////////////////////////
    // next state and controls
    ////////////////////////////////////////

    always_comb begin : ctrl_comb
        next_state    = state;
        next_word_num = word_num;
        proc_busy     = 1'b1; // high unless a request completes
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        wr_word       = 1'b0;
        fill_word     = 1'b0;
        set_tag       = 1'b0;
        clr_dirty     = 1'b0;
        touch         = 1'b0;
        case (state)
            idle: begin
                if (req && hit) begin
                    proc_busy = 1'b0;
                    touch     = 1'b1;
                    wr_word   = proc_wen; // write hit marks frame dirty
                end else if (req) begin
                    next_state = victim_tag.dirty ? write_back : fetch;
                end
            end
            write_back: begin
                mem_wen = 1'b1;
                if (mem_done) begin
                    next_word_num = word_num + 1'b1;
                    if (last_word) begin
                        clr_dirty  = 1'b1; // victim now matches memory
                        next_state = fetch;
                    end
                end
            end
            fetch: begin
                mem_ren = 1'b1;
                if (mem_done) begin
                    fill_word     = 1'b1;
                    next_word_num = word_num + 1'b1;
                    if (last_word) begin
                        set_tag    = 1'b1; // request hits next cycle
                        next_state = idle;
                    end
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin : ctrl_reg
        if (!nRST) begin
            state    <= idle;
            word_num <= '0;
        end else begin
            state    <= next_state;
            word_num <= next_word_num; // wraps to 0 after last word
        end
    end

endmodule

// ==== hdl/lru_order.sv ====
////////////////////////////////////////
// per-set lru order
// update on access, victim read-out
////////////////////////////////////////

`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module lru_order
    import cache_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [`N_SET_BITS-1:0] set_idx,
    input  logic                   touch,      // request completed
    input  way_t                   touch_way,  // way it used
    output way_t                   victim_way
);

    lru_t lru_mem [`N_SETS]; // one order per set
    lru_t cur_order;
    lru_t new_order;
    logic seen;              // touch_way found below position i

    assign cur_order  = lru_mem[set_idx];
    assign victim_way = cur_order[0]; // least recent entry

    // pull touched way out, close the gap, put it on top
    always_comb begin : reorder
        seen      = 1'b0;
        new_order = cur_order;
        for (int i = 0; i < `ASSOC - 1; i++) begin
            if (cur_order[i] == touch_way) begin
                seen = 1'b1;
            end
            if (seen) begin
                new_order[i] = cur_order[i+1]; // shift toward least recent
            end
        end
        new_order[`ASSOC-1] = touch_way;
    end

    always_ff @(posedge CLK, negedge nRST) begin : order_reg
        if (!nRST) begin
            for (int s = 0; s < `N_SETS; s++) begin
                for (int w = 0; w < `ASSOC; w++) begin
                    lru_mem[s][w] <= way_t'(w); // way 0 least recent
                end
            end
        end else if (touch) begin
            lru_mem[set_idx] <= new_order;
        end
    end

endmodule

// ==== hdl/cache_store.sv ====
////////////////////////////////////////
// data, tag, valid and dirty arrays
// hit lookup and victim read-out
////////////////////////////////////////

`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module cache_store
    import bus_pkg::*, cache_pkg::*;
(
    input  logic                     CLK,
    input  logic                     nRST,
    input  cache_addr_u              req_addr,
    input  way_t                     victim_way,
    input  logic [`N_BLOCK_BITS-1:0] word_num,
    input  logic                     wr_word,    // write hit, hit way
    input  logic                     fill_word,  // fetch word, victim way
    input  word_t                    wr_data,
    input  logic                     set_tag,    // fill done, frame valid
    input  logic                     clr_dirty,  // write-back done
    output logic                     hit,
    output way_t                     hit_way,
    output word_t                    hit_word,
    output frame_tag_t               victim_tag,
    output word_t                    victim_word
);

    word_t                  data_mem [`N_SETS][`ASSOC][`BLOCK_SIZE]; // block payload
    frame_tag_t             tag_mem  [`N_SETS][`ASSOC];              // status per frame
    logic [`N_SET_BITS-1:0] set_idx;

    assign set_idx = req_addr.f.set_idx;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    // compare all four ways of the addressed set
    always_comb begin : hit_lookup
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ASSOC; w++) begin
            if (tag_mem[set_idx][w].valid && tag_mem[set_idx][w].tag == req_addr.f.tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_word    = data_mem[set_idx][hit_way][req_addr.f.blk_off];
    assign victim_tag  = tag_mem[set_idx][victim_way];      // dirty decides write-back
    assign victim_word = data_mem[set_idx][victim_way][word_num]; // write-back word

    ////////////////////////////////////////
    // updates
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin : data_write
        if (wr_word) begin
            data_mem[set_idx][hit_way][req_addr.f.blk_off] <= wr_data;
        end else if (fill_word) begin
            data_mem[set_idx][victim_way][word_num] <= wr_data; // one word per mem completion
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin : tag_write
        if (!nRST) begin
            for (int s = 0; s < `N_SETS; s++) begin
                for (int w = 0; w < `ASSOC; w++) begin
                    tag_mem[s][w] <= '0; // invalid and clean
                end
            end
        end else begin
            if (wr_word) begin
                tag_mem[set_idx][hit_way].dirty <= 1'b1;
            end
            if (set_tag) begin
                tag_mem[set_idx][victim_way].valid <= 1'b1;
                tag_mem[set_idx][victim_way].dirty <= 1'b0;
                tag_mem[set_idx][victim_way].tag   <= req_addr.f.tag; // now holds request block
            end else if (clr_dirty) begin
                tag_mem[set_idx][victim_way].dirty <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/cache_pkg.sv ====
////////////////////////////////////////
// cache storage types
// address union, frame tag, lru order, fsm state
////////////////////////////////////////

`include "l2_cache_defs.svh"

package cache_pkg;
    import bus_pkg::*;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    typedef struct packed {
        logic [`N_TAG_BITS-1:0]   tag;      // compared against frame tag
        logic [`N_SET_BITS-1:0]   set_idx;  // selects the set
        logic [`N_BLOCK_BITS-1:0] blk_off;  // word within block
        logic [1:0]               byte_off; // ignored, word access only
    } addr_fields_t;

    // same 32 bits, raw or split
    typedef union packed {
        addr_t        raw;
        addr_fields_t f;
    } cache_addr_u;

    ////////////////////////////////////////
    // frame status and replacement
    ////////////////////////////////////////

    typedef struct packed {
        logic                   valid;
        logic                   dirty; // differs from memory
        logic [`N_TAG_BITS-1:0] tag;
    } frame_tag_t;

    typedef logic [`N_WAY_BITS-1:0] way_t;

    // entry 0 least recent, top entry most recent
    typedef way_t [`ASSOC-1:0] lru_t;

    typedef enum logic [1:0] {
        idle,       // waiting for request, hits served here
        write_back, // dirty victim out to memory
        fetch       // block in from memory
    } ctrl_state_t;

endpackage

// ==== hdl/bus_pkg.sv ====
////////////////////////////////////////
// bus side types
// data word and byte address
////////////////////////////////////////

`include "l2_cache_defs.svh"

package bus_pkg;

    ////////////////////////////////////////
    // processor and memory bus payloads
    ////////////////////////////////////////

    // one data word on either bus
    typedef logic [`WORD_SIZE-1:0] word_t;

    // byte address, always 32 bits
    typedef logic [31:0] addr_t;

endpackage

// ==== hdl/l2_cache_defs.svh ====
////////////////////////////////////////
// size macros for the l2 cache
// word, block, way and set counts plus field widths
////////////////////////////////////////

`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

// storage geometry
`define WORD_SIZE    32   // bits per word
`define BLOCK_SIZE   4    // words per block
`define ASSOC        4    // ways per set
`define N_SETS       8    // sets in the cache

// derived field widths
`define N_BLOCK_BITS 2    // block offset
`define N_SET_BITS   3    // set index
`define N_WAY_BITS   2    // way index

// what is left of the word once set, block and byte bits are taken
`define N_TAG_BITS   25

`endif
